//--- Makefile
# Verilator build and run of the SRAM port testbench

TOP       ?= memPortTb
SEED      ?= 0
LOG       ?= sim.log
VERILATOR ?= verilator
BUILD     ?= obj_dir

FILELIST := memPort.f
SOURCES  := $(shell cat $(FILELIST))
BINARY   := $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timescale 1ns/1ns --top-module $(TOP) \
		-Mdir $(BUILD) -f $(FILELIST)

# The simulator status is ignored, the log decides
run: $(BINARY)
	-$(BINARY) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^TEST RESULT: PASS$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- common/sramPkg.sv
`default_nettype none

package sramPkg;

	////////////////////////////////////////////////////////////
	// Word and address types
	////////////////////////////////////////////////////////////

	// One SRAM word address
	typedef logic [17:0] memAddrT;

	// One data word on the SRAM bus
	typedef logic [15:0] memValueT;

	// Request from the execute stage
	typedef struct packed {
		logic     isRead;
		logic     isWrite;
		memAddrT  addr;
		memValueT wdata;
	} exeReqT;

	////////////////////////////////////////////////////////////
	// Controller states
	////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		idle,
		exeRead1,
		exeRead2,
		exeRead3,
		ifRead1,
		ifRead2,
		ifRead3,
		write1,
		write2,
		write3,
		fault
	} ctrlStateT;

	// Tick every 2**defaultDivBits cycles
	parameter int defaultDivBits = 2;

endpackage

`default_nettype wire

//--- hdl/memPortTop.sv
`default_nettype none

module memPortTop #(
	parameter int divBits = sramPkg::defaultDivBits
) (
	input  logic               clk,
	input  logic               rst,

	// Instruction fetch port
	input  logic               ifReq,
	input  sramPkg::memAddrT   ifAddr,
	output logic               ifBusy,
	output logic               ifDone,
	output sramPkg::memValueT  ifResult,

	// Execute port
	input  logic               exeReq,
	input  sramPkg::exeReqT    exeCmd,
	output logic               exeBusy,
	output logic               exeDone,
	output sramPkg::memValueT  exeResult,

	// Status
	output logic               faultFlag,
	output sramPkg::ctrlStateT ctrlState,

	// SRAM pins
	output sramPkg::memAddrT   ramAddr,
	inout  wire sramPkg::memValueT ramData,
	output logic               ramOe,
	output logic               ramWe,
	output logic               ramEn
);

	import sramPkg::*;

	// Payloads held between the two stages
	memAddrT ifAddrHeld;
	exeReqT  exeHeld;

	////////////////////////////////////////////////////////////
	// Request capture, pending levels double as busy
	////////////////////////////////////////////////////////////

	reqCapture capture0 (
		.clk        (clk),
		.rst        (rst),
		.ifReq      (ifReq),
		.ifAddr     (ifAddr),
		.exeReq     (exeReq),
		.exeCmd     (exeCmd),
		.ifDone     (ifDone),
		.exeDone    (exeDone),
		.ifPending  (ifBusy),
		.exePending (exeBusy),
		.ifAddrHeld (ifAddrHeld),
		.exeHeld    (exeHeld)
	);

	////////////////////////////////////////////////////////////
	// SRAM controller
	////////////////////////////////////////////////////////////

	sramCtrl #(
		.divBits (divBits)
	) ctrl0 (
		.clk        (clk),
		.rst        (rst),
		.ifPending  (ifBusy),
		.exePending (exeBusy),
		.ifAddrHeld (ifAddrHeld),
		.exeHeld    (exeHeld),
		.ramAddr    (ramAddr),
		.ramData    (ramData),
		.ramOe      (ramOe),
		.ramWe      (ramWe),
		.ramEn      (ramEn),
		.ifDone     (ifDone),
		.exeDone    (exeDone),
		.ifResult   (ifResult),
		.exeResult  (exeResult),
		.faultFlag  (faultFlag),
		.ctrlState  (ctrlState)
	);

endmodule

`default_nettype wire

//--- hdl/reqCapture.sv
`default_nettype none

module reqCapture (
	input  logic             clk,
	input  logic             rst,

	// Client strobes and payloads
	input  logic             ifReq,
	input  sramPkg::memAddrT ifAddr,
	input  logic             exeReq,
	input  sramPkg::exeReqT  exeCmd,

	// Completion levels from the controller
	input  logic             ifDone,
	input  logic             exeDone,

	// Held requests toward the controller
	output logic             ifPending,
	output logic             exePending,
	output sramPkg::memAddrT ifAddrHeld,
	output sramPkg::exeReqT  exeHeld
);

	// Registered copies of done, for edge detection
	logic ifDoneQ;
	logic exeDoneQ;
	logic ifDoneRise;
	logic exeDoneRise;

	assign ifDoneRise  = ifDone & ~ifDoneQ;
	assign exeDoneRise = exeDone & ~exeDoneQ;

	////////////////////////////////////////////////////////////
	// Pending levels
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ifDoneQ    <= 1'b0;
			exeDoneQ   <= 1'b0;
			ifPending  <= 1'b0;
			exePending <= 1'b0;
		end else begin
			ifDoneQ  <= ifDone;
			exeDoneQ <= exeDone;

			// A strobe is taken only while the port is free
			if (!ifPending && ifReq) begin
				ifPending <= 1'b1;
			end else if (ifDoneRise) begin
				ifPending <= 1'b0;
			end

			if (!exePending && exeReq) begin
				exePending <= 1'b1;
			end else if (exeDoneRise) begin
				exePending <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Held payloads
	////////////////////////////////////////////////////////////

	// Loaded together with the pending level, then frozen
	always_ff @(posedge clk) begin
		if (!ifPending && ifReq) begin
			ifAddrHeld <= ifAddr;
		end
		if (!exePending && exeReq) begin
			exeHeld <= exeCmd;
		end
	end

endmodule

`default_nettype wire

//--- memPort.f
common/sramPkg.sv
hdl/reqCapture.sv
sramCtrl/sramCtrl.sv
hdl/memPortTop.sv
tests/sramModel.sv
tests/memPortTb.sv

//--- sramCtrl/sramCtrl.sv
`default_nettype none

module sramCtrl #(
	parameter int divBits = sramPkg::defaultDivBits
) (
	input  logic               clk,
	input  logic               rst,

	// Held requests from the capture stage
	input  logic               ifPending,
	input  logic               exePending,
	input  sramPkg::memAddrT   ifAddrHeld,
	input  sramPkg::exeReqT    exeHeld,

	// SRAM chip pins, all strobes active low
	output sramPkg::memAddrT   ramAddr,
	inout  wire sramPkg::memValueT ramData,
	output logic               ramOe,
	output logic               ramWe,
	output logic               ramEn,

	// Completion and results
	output logic               ifDone,
	output logic               exeDone,
	output sramPkg::memValueT  ifResult,
	output sramPkg::memValueT  exeResult,
	output logic               faultFlag,
	output sramPkg::ctrlStateT ctrlState
);

	import sramPkg::*;

	ctrlStateT state;
	ctrlStateT nextState;

	logic [divBits-1:0] cnt;
	logic               tick;

	// Write data register and bus drive enable
	memValueT dataOut;
	logic     writing;

	assign tick      = (cnt == '0);
	assign ramData   = writing ? dataOut : 'z;
	assign faultFlag = (state == fault);
	assign ctrlState = state;

	////////////////////////////////////////////////////////////
	// Divider, state register and done levels
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cnt     <= '0;
			state   <= idle;
			exeDone <= 1'b0;
			ifDone  <= 1'b0;
		end else begin
			cnt <= cnt + 1'b1;
			if (tick) begin
				state <= nextState;

				// Done falls as the port's next access starts
				if (nextState == exeRead1 || nextState == write1) begin
					exeDone <= 1'b0;
				end
				if (state == exeRead3 || state == write3) begin
					exeDone <= 1'b1;
				end

				if (nextState == ifRead1) begin
					ifDone <= 1'b0;
				end
				if (state == ifRead3) begin
					ifDone <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////

	always_comb begin
		case (state)
			idle: begin
				// EXE wins over IF
				if (exePending) begin
					if (exeHeld.isWrite) begin
						nextState = write1;
					end else if (exeHeld.isRead) begin
						nextState = exeRead1;
					end else begin
						nextState = fault;
					end
				end else if (ifPending) begin
					nextState = ifRead1;
				end else begin
					nextState = idle;
				end
			end

			exeRead1: nextState = exeRead2;
			exeRead2: nextState = exeRead3;
			exeRead3: nextState = idle;

			ifRead1:  nextState = ifRead2;
			ifRead2:  nextState = ifRead3;
			ifRead3:  nextState = idle;

			write1:   nextState = write2;
			write2:   nextState = write3;
			write3:   nextState = idle;

			// Sticky until reset
			default:  nextState = fault;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Pin strobes
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ramOe   <= 1'b1;
			ramWe   <= 1'b1;
			ramEn   <= 1'b0;
			writing <= 1'b0;
		end else begin
			case (state)
				exeRead1, exeRead2, exeRead3,
				ifRead1, ifRead2, ifRead3: begin
					ramOe   <= 1'b0;
					ramWe   <= 1'b1;
					ramEn   <= 1'b0;
					writing <= 1'b0;
				end

				write1, write3: begin
					ramOe   <= 1'b1;
					ramWe   <= 1'b1;
					ramEn   <= 1'b0;
					writing <= 1'b1;
				end

				write2: begin
					ramOe   <= 1'b1;
					ramWe   <= 1'b0;
					ramEn   <= 1'b0;
					writing <= 1'b1;
				end

				fault: begin
					// Chip deselected once broken
					ramOe   <= 1'b1;
					ramWe   <= 1'b1;
					ramEn   <= 1'b1;
					writing <= 1'b0;
				end

				default: begin
					ramOe   <= 1'b1;
					ramWe   <= 1'b1;
					ramEn   <= 1'b0;
					writing <= 1'b0;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Address, write data and results
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		case (state)
			exeRead1: ramAddr <= exeHeld.addr;
			ifRead1:  ramAddr <= ifAddrHeld;
			write1: begin
				ramAddr <= exeHeld.addr;
				dataOut <= exeHeld.wdata;
			end

			// Last sample before the tick wins
			exeRead3: exeResult <= ramData;
			ifRead3:  ifResult  <= ramData;

			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- tests/memPortTb.sv
`default_nettype none

module memPortTb;

	timeunit 1ns;
	timeprecision 100ps;

	import sramPkg::*;

	localparam int divBits     = defaultDivBits;
	localparam int tickCycles  = 1 << divBits;
	localparam int accessLimit = 12 * tickCycles;
	localparam int numWords    = 64;
	localparam int numIfReads  = 32;
	localparam int numRounds   = 4;
	// All accesses of the run, dropped strobes and the fault included
	localparam int numOps      = 2 * numWords + numIfReads + 2 * numRounds + 12;

	logic          clk;
	logic          rst;
	logic          ifReq;
	memAddrT       ifAddr;
	logic          ifBusy;
	logic          ifDone;
	memValueT      ifResult;
	logic          exeReq;
	exeReqT        exeCmd;
	logic          exeBusy;
	logic          exeDone;
	memValueT      exeResult;
	logic          faultFlag;
	ctrlStateT     ctrlState;
	memAddrT       ramAddr;
	wire memValueT ramData;
	logic          ramOe;
	logic          ramWe;
	logic          ramEn;

	// Reference model of every word written so far
	memValueT shadow [memAddrT];
	memAddrT  written [$];

	// Done rise counters and the cycles at which each port freed up
	int   ifEdges = 0;
	int   exeEdges = 0;
	logic ifDoneLast = 1'b0;
	logic exeDoneLast = 1'b0;
	int   exeFreeAt;
	int   ifFreeAt;

	memPortTop #(
		.divBits (divBits)
	) dut0 (
		.clk       (clk),
		.rst       (rst),
		.ifReq     (ifReq),
		.ifAddr    (ifAddr),
		.ifBusy    (ifBusy),
		.ifDone    (ifDone),
		.ifResult  (ifResult),
		.exeReq    (exeReq),
		.exeCmd    (exeCmd),
		.exeBusy   (exeBusy),
		.exeDone   (exeDone),
		.exeResult (exeResult),
		.faultFlag (faultFlag),
		.ctrlState (ctrlState),
		.ramAddr   (ramAddr),
		.ramData   (ramData),
		.ramOe     (ramOe),
		.ramWe     (ramWe),
		.ramEn     (ramEn)
	);

	sramModel ram0 (
		.ramAddr (ramAddr),
		.ramData (ramData),
		.ramOe   (ramOe),
		.ramWe   (ramWe),
		.ramEn   (ramEn)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(negedge clk) begin
		ifDoneLast  <= ifDone;
		exeDoneLast <= exeDone;
		if (ifDone && !ifDoneLast) begin
			ifEdges <= ifEdges + 1;
		end
		if (exeDone && !exeDoneLast) begin
			exeEdges <= exeEdges + 1;
		end
	end

	// Sixteen ticks per operation bound the whole run
	initial begin
		repeat (numOps * 16 * tickCycles) @(posedge clk);
		abortRun("Watchdog expired before all tests finished");
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic checkEqual(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Check %s failed", name);
		end
	endtask

	task automatic strobeRequests(input logic doExe, input exeReqT cmd,
			input logic doIf, input memAddrT addr);
		@(posedge clk);
		exeReq <= doExe;
		exeCmd <= cmd;
		ifReq  <= doIf;
		ifAddr <= addr;
		@(posedge clk);
		exeReq <= 1'b0;
		ifReq  <= 1'b0;
	endtask

	// Wait on falling edges until both busy levels are low
	task automatic waitFree(input string name);
		int   cycles;
		logic free;
		cycles    = 0;
		free      = 1'b0;
		exeFreeAt = -1;
		ifFreeAt  = -1;
		while (!free) begin
			@(negedge clk);
			if (!exeBusy && exeFreeAt < 0) begin
				exeFreeAt = cycles;
			end
			if (!ifBusy && ifFreeAt < 0) begin
				ifFreeAt = cycles;
			end
			free   = !exeBusy && !ifBusy;
			cycles = cycles + 1;
			if (!free && cycles > accessLimit) begin
				abortRun({name, ": access did not complete in time"});
			end
		end
	endtask

	task automatic exeAccess(input string name, input logic isWrite, input memAddrT addr,
			input memValueT data);
		exeReqT cmd;
		cmd.isRead  = !isWrite;
		cmd.isWrite = isWrite;
		cmd.addr    = addr;
		cmd.wdata   = data;
		strobeRequests(1'b1, cmd, 1'b0, '0);
		waitFree(name);
		checkEqual({name, " exeDone"}, 32'd1, 32'(exeDone));
		if (isWrite) begin
			shadow[addr] = data;
		end else begin
			checkEqual({name, " exeResult"}, 32'(shadow[addr]), 32'(exeResult));
		end
	endtask

	task automatic ifRead(input string name, input memAddrT addr);
		strobeRequests(1'b0, '0, 1'b1, addr);
		waitFree(name);
		checkEqual({name, " ifDone"}, 32'd1, 32'(ifDone));
		checkEqual({name, " ifResult"}, 32'(shadow[addr]), 32'(ifResult));
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		exeReqT   cmd;
		memAddrT  addr;
		memAddrT  other;
		memValueT data;
		int       exeBefore;
		int       ifBefore;
		int       cycles;

		void'($urandom(32'h6283_7d3d));
		rst    = 1'b0;
		ifReq  = 1'b0;
		ifAddr = '0;
		exeReq = 1'b0;
		exeCmd = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b1;

		// Idle pins after reset
		@(negedge clk);
		checkEqual("reset ramOe", 32'd1, 32'(ramOe));
		checkEqual("reset ramWe", 32'd1, 32'(ramWe));
		checkEqual("reset ramEn", 32'd0, 32'(ramEn));
		checkEqual("reset ifDone", 32'd0, 32'(ifDone));
		checkEqual("reset exeDone", 32'd0, 32'(exeDone));
		checkEqual("reset faultFlag", 32'd0, 32'(faultFlag));
		checkEqual("reset ctrlState", 32'(idle), 32'(ctrlState));

		// Distinct random addresses, written then read back over EXE
		while (written.size() < numWords) begin
			addr = memAddrT'($urandom);
			if (!shadow.exists(addr)) begin
				exeAccess("exe write", 1'b1, addr, memValueT'($urandom));
				written.push_back(addr);
			end
		end
		foreach (written[i]) begin
			exeAccess("exe read", 1'b0, written[i], '0);
		end

		repeat (numIfReads) begin
			ifRead("if read", written[$urandom_range(numWords - 1)]);
		end

		// Both ports at once, EXE must finish first
		for (int round = 0; round < numRounds; round++) begin
			addr        = written[$urandom_range(numWords - 1)];
			other       = written[$urandom_range(numWords - 1)];
			data        = memValueT'($urandom);
			cmd.isRead  = (round % 2 == 0);
			cmd.isWrite = (round % 2 == 1);
			// Odd rounds write the word that IF fetches right after
			cmd.addr    = cmd.isWrite ? addr : other;
			cmd.wdata   = data;
			exeBefore   = exeEdges;
			ifBefore    = ifEdges;
			strobeRequests(1'b1, cmd, 1'b1, addr);
			waitFree("simultaneous");
			checkEqual("simultaneous order", 32'd1, 32'(exeFreeAt < ifFreeAt));
			checkEqual("simultaneous exe edges", exeBefore + 1, exeEdges);
			checkEqual("simultaneous if edges", ifBefore + 1, ifEdges);
			if (cmd.isWrite) begin
				shadow[addr] = data;
			end else begin
				checkEqual("simultaneous exeResult", 32'(shadow[other]), 32'(exeResult));
			end
			checkEqual("simultaneous ifResult", 32'(shadow[addr]), 32'(ifResult));
		end

		// Second strobe lands while the port is busy
		addr        = written[0];
		other       = written[1];
		data        = ~shadow[addr];
		cmd.isRead  = 1'b0;
		cmd.isWrite = 1'b1;
		cmd.addr    = addr;
		cmd.wdata   = data;
		exeBefore   = exeEdges;
		strobeRequests(1'b1, cmd, 1'b0, '0);
		cmd.addr    = other;
		cmd.wdata   = ~shadow[other];
		strobeRequests(1'b1, cmd, 1'b0, '0);
		waitFree("busy exe");
		shadow[addr] = data;
		repeat (4 * tickCycles) @(negedge clk);
		checkEqual("busy exe done edges", exeBefore + 1, exeEdges);
		checkEqual("busy exe port", 32'd0, 32'(exeBusy));
		exeAccess("busy exe readback", 1'b0, addr, '0);
		exeAccess("busy exe untouched", 1'b0, other, '0);

		ifBefore = ifEdges;
		strobeRequests(1'b0, '0, 1'b1, addr);
		strobeRequests(1'b0, '0, 1'b1, other);
		waitFree("busy if");
		checkEqual("busy if result", 32'(shadow[addr]), 32'(ifResult));
		repeat (4 * tickCycles) @(negedge clk);
		checkEqual("busy if done edges", ifBefore + 1, ifEdges);

		// Neither read nor write locks the controller up
		cmd.isRead  = 1'b0;
		cmd.isWrite = 1'b0;
		cmd.addr    = written[2];
		strobeRequests(1'b1, cmd, 1'b0, '0);
		cycles = 0;
		while (!faultFlag) begin
			@(negedge clk);
			cycles = cycles + 1;
			if (cycles > accessLimit) begin
				abortRun("faultFlag never rose after an EXE request with no operation");
			end
		end
		checkEqual("fault state", 32'(fault), 32'(ctrlState));
		exeBefore = exeEdges;
		ifBefore  = ifEdges;
		strobeRequests(1'b0, '0, 1'b1, written[2]);
		repeat (8 * tickCycles) @(negedge clk);
		checkEqual("fault if edges", ifBefore, ifEdges);
		checkEqual("fault exe edges", exeBefore, exeEdges);
		checkEqual("fault flag held", 32'd1, 32'(faultFlag));

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/sramModel.sv
`default_nettype none

module sramModel (
	input  sramPkg::memAddrT       ramAddr,
	inout  wire sramPkg::memValueT ramData,
	input  logic                   ramOe,
	input  logic                   ramWe,
	input  logic                   ramEn
);

	timeunit 1ns;
	timeprecision 100ps;

	import sramPkg::*;

	localparam int depth = 1 << $bits(memAddrT);

	memValueT mem [0:depth-1];

	// Set by a falling WE so that the rising WE commits the word
	logic weArmed = 1'b0;

	// Chip drives the bus only for an enabled read
	assign ramData = (!ramEn && !ramOe && ramWe) ? mem[ramAddr] : 'z;

	// Fill word mixes in every address bit
	initial begin
		for (int a = 0; a < depth; a++) begin
			mem[a] = memValueT'(a) ^ {2'(a >> 16), 14'h1d35};
		end
	end

	// Async SRAM latches the write at the end of the WE pulse
	always @(ramWe) begin
		if (!ramWe) begin
			weArmed = 1'b1;
		end else begin
			if (weArmed && !ramEn) begin
				mem[ramAddr] = ramData;
			end
			weArmed = 1'b0;
		end
	end

endmodule

`default_nettype wire
